// ==== banked_mem.f ====
+incdir+common
common/mem_cmd_pkg.sv
common/mem_ctl_pkg.sv
common/bank_if.sv
sram_bank/sram_bank.sv
logic/cmd_router.sv
logic/resp_merge.sv
logic/banked_mem.sv
tests/banked_mem_assert.sv
tests/banked_mem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the banked memory testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=banked_mem_sim
LOG=sim.log

rm -rf "$BUILD_DIR" "$LOG"

verilator --binary --timing --assert -Wno-fatal \
   --timescale 1ns/100ps \
   --top-module banked_mem_tb \
   -Mdir "$BUILD_DIR" -o "$SIM_BIN" \
   -f banked_mem.f
if [ $? -ne 0 ]; then
   echo "Build failed"
   exit 1
fi

"./$BUILD_DIR/$SIM_BIN" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -F -x -q "** PASS **" "$LOG"; then
   exit 0
fi

echo "Pass message not found in $LOG"
exit 1

// ==== tests/banked_mem_tb.sv ====
// Testbench for the banked memory: stimulus, reference model and response checking

`include "mem_consts.svh"

module banked_mem_tb import mem_cmd_pkg::*; ();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int WAIT_LIMIT  = 2000;                    // Cycles
   localparam int READY_LIMIT = 4 * `MEM_BANK_WORDS;
   localparam int MODEL_WORDS = 2 * `MEM_BANK_WORDS;
   localparam int IDX_HI      = $clog2(MODEL_WORDS) + 1;  // Bank bit included

   logic                 clk;
   logic                 rst;
   logic                 cmd_valid;
   logic                 cmd_ready;
   mem_op_e              cmd_op;
   logic [`MEM_AW-1:0]   cmd_addr;
   logic [`MEM_DW-1:0]   cmd_wdata;
   logic [`MEM_BE_W-1:0] cmd_be;
   logic                 rsp_valid;
   logic                 rsp_ready;
   logic [`MEM_DW-1:0]   rsp_rdata;

   logic [`MEM_DW-1:0]   model_mem [MODEL_WORDS];
   logic [`MEM_DW-1:0]   exp_q [$];
   logic                 bp_random;
   string                test_name;
   int                   cmd_count;
   int                   rsp_count;
   int                   check_count;
   int                   error_count;
   int                   test_count;
   int                   test_errors;
   int                   test_first_cmd;
   int                   test_first_rsp;

   banked_mem UUT (
      .clk       (clk),
      .rst       (rst),
      .cmd_valid (cmd_valid),
      .cmd_ready (cmd_ready),
      .cmd_op    (cmd_op),
      .cmd_addr  (cmd_addr),
      .cmd_wdata (cmd_wdata),
      .cmd_be    (cmd_be),
      .rsp_valid (rsp_valid),
      .rsp_ready (rsp_ready),
      .rsp_rdata (rsp_rdata)
   );

   bind banked_mem banked_mem_assert u_assert (
      .clk        (clk),
      .rst        (rst),
      .rsp_valid  (rsp_valid),
      .rsp_ready  (rsp_ready),
      .rsp_rdata  (rsp_rdata),
      .cmd_ready  (cmd_ready),
      .order_full (order_full)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Word index is the byte address without bits 1:0, bank bit included
   function automatic logic [`MEM_DW-1:0] model_access(input mem_op_e op,
         input logic [`MEM_AW-1:0] addr, input logic [`MEM_DW-1:0] wdata,
         input logic [`MEM_BE_W-1:0] be);
      int idx;
      idx = int'(addr[IDX_HI:2]);
      if (op == OP_READ) begin
         return model_mem[idx];
      end
      for (int b = 0; b < `MEM_BE_W; b++) begin
         if (be[b]) begin
            model_mem[idx][8*b +: 8] = wdata[8*b +: 8];
         end
      end
      return '0;
   endfunction

   task automatic note_error();
      error_count++;
      test_errors++;
   endtask

   task automatic stop_on_timeout(input string what);
      $display("Timeout in test %s: %s", test_name, what);
      $display("** FAIL **");
      $finish;
   endtask

   // Called on a rising edge, returns on the accepting edge
   task automatic send_cmd(input mem_op_e op, input logic [`MEM_AW-1:0] addr,
         input logic [`MEM_DW-1:0] wdata, input logic [`MEM_BE_W-1:0] be);
      int   waited;
      logic taken;
      waited = 0;
      taken  = 1'b0;
      #1;
      cmd_valid = 1'b1;
      cmd_op    = op;
      cmd_addr  = addr;
      cmd_wdata = wdata;
      cmd_be    = be;
      while (!taken) begin
         @(negedge clk);
         if (cmd_ready) begin
            taken = 1'b1;
         end else begin
            waited++;
            if (waited > WAIT_LIMIT) begin
               stop_on_timeout("cmd_ready stayed low");
            end
         end
         @(posedge clk);
      end
      exp_q.push_back(model_access(op, addr, wdata, be));
      cmd_count++;
   endtask

   task automatic send_random(input int words);
      mem_op_e            op;
      logic [`MEM_AW-1:0] addr;
      op   = ($urandom_range(0, 1) == 0) ? OP_READ : OP_WRITE;
      addr = `MEM_AW'($urandom_range(0, words - 1) * 4 + $urandom_range(0, 3));
      send_cmd(op, addr, $urandom(), `MEM_BE_W'($urandom()));
   endtask

   task automatic start_test(input string name);
      test_name      = name;
      test_errors    = 0;
      test_first_cmd = cmd_count;
      test_first_rsp = rsp_count;
   endtask

   task automatic finish_test();
      int waited;
      int n_cmd;
      int n_rsp;
      waited = 0;
      #1;
      cmd_valid = 1'b0;
      while (rsp_count < cmd_count) begin
         @(posedge clk);
         waited++;
         if (waited > WAIT_LIMIT) begin
            stop_on_timeout("rsp_valid never came for an outstanding command");
         end
      end
      repeat (`MEM_BANK_DELAY + 2) @(posedge clk);       // Lets stray responses show
      n_cmd = cmd_count - test_first_cmd;
      n_rsp = rsp_count - test_first_rsp;
      assert (n_rsp == n_cmd) else begin
         $display("CHECK FAILED %s response count: expected %0d, actual %0d",
                  test_name, n_cmd, n_rsp);
         note_error();
      end
      test_count++;
      $display("Test %s: %0d commands, %0d responses, %0d errors",
               test_name, n_cmd, n_rsp, test_errors);
   endtask

   // Response sampled mid-cycle, the transfer follows on the next rising edge
   initial begin
      logic [`MEM_DW-1:0] expected;
      forever begin
         @(negedge clk);
         if (!rst && rsp_valid && rsp_ready) begin
            rsp_count++;
            assert (exp_q.size() > 0) else begin
               $display("Test %s: a response came with no command outstanding", test_name);
               note_error();
            end
            if (exp_q.size() > 0) begin
               expected = exp_q.pop_front();
               check_count++;
               assert (rsp_rdata === expected) else begin
                  $display("CHECK FAILED %s: expected %h, actual %h",
                           test_name, expected, rsp_rdata);
                  note_error();
               end
            end
         end
      end
   end

   initial begin
      rsp_ready = 1'b0;
      forever begin
         @(posedge clk);
         #1;
         rsp_ready = bp_random ? 1'($urandom_range(0, 1)) : 1'b1;
      end
   end

   initial begin
      int waited;
      void'($urandom(32'hd2df_62e8));
      rst         = 1'b1;
      cmd_valid   = 1'b0;
      cmd_op      = OP_READ;
      cmd_addr    = '0;
      cmd_wdata   = '0;
      cmd_be      = '0;
      bp_random   = 1'b0;
      test_name   = "reset";
      cmd_count   = 0;
      rsp_count   = 0;
      check_count = 0;
      error_count = 0;
      test_count  = 0;
      test_errors = 0;
      for (int i = 0; i < MODEL_WORDS; i++) begin
         model_mem[i] = '0;
      end

      repeat (4) @(posedge clk);
      #1;
      rst = 1'b0;
      waited = 0;
      @(negedge clk);
      while (!cmd_ready) begin                          // Banks clear their arrays first
         waited++;
         if (waited > READY_LIMIT) begin
            stop_on_timeout("cmd_ready never rose after reset");
         end
         @(negedge clk);
      end
      @(posedge clk);

      start_test("reset_contents");
      for (int i = 0; i < 8; i++) begin
         send_cmd(OP_READ, `MEM_AW'(i * 16'h0404), '0, '0);   // Alternates banks
      end
      finish_test();

      start_test("full_word");
      for (int i = 0; i < 8; i++) begin
         send_cmd(OP_WRITE, `MEM_AW'(16'h0040 + 4 * i), $urandom(), '1);
      end
      for (int i = 0; i < 8; i++) begin
         send_cmd(OP_READ, `MEM_AW'(16'h0040 + 4 * i), '0, '0);
      end
      finish_test();

      start_test("byte_mask");
      for (int i = 0; i < 4; i++) begin
         send_cmd(OP_WRITE, `MEM_AW'(16'h0200 + 4 * i), 32'h1122_3344 + i, '1);
      end
      for (int m = 0; m < 16; m++) begin
         send_cmd(OP_WRITE, `MEM_AW'(16'h0200 + 4 * (m % 4)), $urandom(), `MEM_BE_W'(m));
         send_cmd(OP_READ, `MEM_AW'(16'h0200 + 4 * (m % 4)), '0, '0);
      end
      finish_test();

      start_test("interleaved");
      for (int i = 0; i < 16; i++) begin
         send_cmd(OP_WRITE, `MEM_AW'(16'h0300 + 4 * i), 32'hA5A5_0000 | i, '1);
      end
      for (int i = 0; i < 16; i++) begin
         send_cmd(OP_READ, `MEM_AW'(16'h0300 + 4 * i), '0, '0);
      end
      finish_test();

      start_test("back_pressure");
      bp_random = 1'b1;
      for (int i = 0; i < 100; i++) begin
         send_random(64);
      end
      finish_test();
      bp_random = 1'b0;

      start_test("random_mix");
      for (int i = 0; i < 300; i++) begin
         send_random(16);
      end
      finish_test();

      error_count += int'(UUT.u_assert.fail_count);
      $display("Summary: %0d tests, %0d commands, %0d checks, %0d errors",
               test_count, cmd_count, check_count, error_count);
      if (error_count == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

// ==== tests/banked_mem_assert.sv ====
// Handshake assertions for the banked memory top level

`include "mem_consts.svh"

module banked_mem_assert (
   input logic               clk,
   input logic               rst,
   input logic               rsp_valid,
   input logic               rsp_ready,
   input logic [`MEM_DW-1:0] rsp_rdata,
   input logic               cmd_ready,
   input logic               order_full
);
   timeunit 1ns;
   timeprecision 100ps;

   int unsigned fail_count = 0;               // Read by the testbench at the end

   // Response held under back-pressure
   property rsp_held_p;
      @(posedge clk) disable iff (rst)
         (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp_rdata));
   endproperty

   property rsp_low_after_reset_p;
      @(posedge clk) rst |=> !rsp_valid;
   endproperty

   property no_accept_when_full_p;
      @(posedge clk) disable iff (rst) order_full |-> !cmd_ready;
   endproperty

   rsp_held_a: assert property (rsp_held_p) else begin
      fail_count++;
      $error("rsp_valid or rsp_rdata changed while rsp_ready was low");
   end

   rsp_low_after_reset_a: assert property (rsp_low_after_reset_p) else begin
      fail_count++;
      $error("rsp_valid was high right after reset");
   end

   no_accept_when_full_a: assert property (no_accept_when_full_p) else begin
      fail_count++;
      $error("cmd_ready was high while the order queue was full");
   end

endmodule

// ==== logic/banked_mem.sv ====
// Banked memory top: router, even and odd SRAM banks and in-order merger

`include "mem_consts.svh"

module banked_mem import mem_cmd_pkg::*, mem_ctl_pkg::*; (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 cmd_valid,
   output logic                 cmd_ready,
   input  mem_op_e              cmd_op,
   input  logic [`MEM_AW-1:0]   cmd_addr,
   input  logic [`MEM_DW-1:0]   cmd_wdata,
   input  logic [`MEM_BE_W-1:0] cmd_be,
   output logic                 rsp_valid,
   input  logic                 rsp_ready,
   output logic [`MEM_DW-1:0]   rsp_rdata
);

   mem_cmd_t   cmd;
   logic       order_push;
   bank_sel_t  order_bank;
   logic       order_full;

   bank_if even_if ();
   bank_if odd_if ();

   assign cmd = '{op: cmd_op, addr: cmd_addr, wdata: cmd_wdata, be: cmd_be};

   cmd_router u_router (
      .clk        (clk),
      .rst        (rst),
      .cmd_valid  (cmd_valid),
      .cmd_ready  (cmd_ready),
      .cmd        (cmd),
      .even       (even_if.router),
      .odd        (odd_if.router),
      .order_push (order_push),
      .order_bank (order_bank),
      .order_full (order_full)
   );

   sram_bank u_even_bank (
      .clk (clk),
      .rst (rst),
      .bus (even_if.bank)
   );

   sram_bank u_odd_bank (
      .clk (clk),
      .rst (rst),
      .bus (odd_if.bank)
   );

   resp_merge u_merge (
      .clk        (clk),
      .rst        (rst),
      .even       (even_if.merge),
      .odd        (odd_if.merge),
      .order_push (order_push),
      .order_bank (order_bank),
      .order_full (order_full),
      .rsp_valid  (rsp_valid),
      .rsp_ready  (rsp_ready),
      .rsp_rdata  (rsp_rdata)
   );

endmodule

// ==== logic/resp_merge.sv ====
// Response merger: returns bank responses in command order

`include "mem_consts.svh"

module resp_merge import mem_ctl_pkg::*; (
   input  logic               clk,
   input  logic               rst,
   bank_if.merge              even,
   bank_if.merge              odd,
   input  logic               order_push,
   input  bank_sel_t          order_bank,
   output logic               order_full,
   output logic               rsp_valid,
   input  logic               rsp_ready,
   output logic [`MEM_DW-1:0] rsp_rdata
);

   localparam int PTR_W = $clog2(`MEM_ORDER_DEPTH);

   bank_sel_t         order_q [`MEM_ORDER_DEPTH];
   logic [PTR_W-1:0]  wr_ptr;
   logic [PTR_W-1:0]  rd_ptr;
   logic [PTR_W:0]    count;
   logic              q_empty;
   logic              pop;
   bank_sel_t         head;

   assign q_empty    = (count == '0);
   assign order_full = (count == (PTR_W+1)'(`MEM_ORDER_DEPTH));
   assign head       = order_q[rd_ptr];

   assign rsp_valid = !q_empty && ((head == BANK_ODD) ? odd.r_valid : even.r_valid);
   assign rsp_rdata = (head == BANK_ODD) ? odd.r_rdata : even.r_rdata;

   // Only the head bank sees the top-level ready
   assign even.r_ready = !q_empty && (head == BANK_EVEN) && rsp_ready;
   assign odd.r_ready  = !q_empty && (head == BANK_ODD) && rsp_ready;

   assign pop = rsp_valid && rsp_ready;

   always_ff @(posedge clk) begin
      if (order_push) begin
         order_q[wr_ptr] <= order_bank;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (order_push) begin
            wr_ptr <= wr_ptr + 1'b1;            // Wraps at the depth
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({order_push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

// ==== logic/cmd_router.sv ====
// Command router: steers each command to its bank and records command order

`include "mem_consts.svh"

module cmd_router import mem_cmd_pkg::*, mem_ctl_pkg::*; (
   input  logic       clk,
   input  logic       rst,
   input  logic       cmd_valid,
   output logic       cmd_ready,
   input  mem_cmd_t   cmd,
   bank_if.router     even,
   bank_if.router     odd,
   output logic       order_push,
   output bank_sel_t  order_bank,
   input  logic       order_full
);

   bank_sel_t   sel;
   logic [1:0]  in_flight;                    // One bit per bank
   logic        even_open;
   logic        odd_open;

   assign sel = bank_sel_t'(cmd.addr[2]);

   // A bank is open when it holds no command and the order queue has room
   assign even_open = !in_flight[BANK_EVEN] && !order_full;
   assign odd_open  = !in_flight[BANK_ODD] && !order_full;

   assign even.c_valid = cmd_valid && (sel == BANK_EVEN) && even_open;
   assign odd.c_valid  = cmd_valid && (sel == BANK_ODD) && odd_open;
   assign even.c_cmd   = cmd;
   assign odd.c_cmd    = cmd;

   always_comb begin
      if (sel == BANK_ODD) begin
         cmd_ready = odd.c_ready && odd_open;
      end else begin
         cmd_ready = even.c_ready && even_open;
      end
   end

   assign order_push = cmd_valid && cmd_ready;
   assign order_bank = sel;

   // Set on accept, cleared when the bank's response leaves
   always_ff @(posedge clk) begin
      if (rst) begin
         in_flight <= '0;
      end else begin
         if (even.r_valid && even.r_ready) begin
            in_flight[BANK_EVEN] <= 1'b0;
         end
         if (odd.r_valid && odd.r_ready) begin
            in_flight[BANK_ODD] <= 1'b0;
         end
         if (order_push) begin
            in_flight[order_bank] <= 1'b1;
         end
      end
   end

endmodule

// ==== sram_bank/sram_bank.sv ====
// SRAM bank: fixed-latency handshake word memory with byte-masked writes

`include "mem_consts.svh"

module sram_bank import mem_cmd_pkg::*, mem_ctl_pkg::*; (
   input logic     clk,
   input logic     rst,
   bank_if.bank    bus
);

   localparam int IDX_W = $clog2(`MEM_BANK_WORDS);
   localparam int CNT_W = ($clog2(`MEM_BANK_DELAY) > 0) ? $clog2(`MEM_BANK_DELAY) : 1;

   logic [`MEM_DW-1:0]  mem [`MEM_BANK_WORDS];

   bank_state_e         state;
   logic [CNT_W-1:0]    lat_cnt;
   logic                sweep_on;
   logic [IDX_W-1:0]    sweep_idx;

   mem_cmd_t            cmd_r;
   logic [IDX_W-1:0]    word_idx;
   logic                accept;
   logic                do_access;

   assign bus.c_ready = (state == BANK_IDLE) && !sweep_on;
   assign bus.r_valid = (state == BANK_DONE);

   assign accept    = bus.c_valid && bus.c_ready;
   assign do_access = (state == BANK_BUSY) && (lat_cnt == '0);   // Last latency cycle
   assign word_idx  = cmd_r.addr[3 +: IDX_W];                     // Bit 2 is the bank select

   // Zero the array once after reset, one word per cycle
   always_ff @(posedge clk) begin
      if (rst) begin
         sweep_on  <= 1'b1;
         sweep_idx <= '0;
      end else if (sweep_on) begin
         if (sweep_idx == IDX_W'(`MEM_BANK_WORDS - 1)) begin
            sweep_on <= 1'b0;
         end
         sweep_idx <= sweep_idx + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state   <= BANK_IDLE;
         lat_cnt <= '0;
      end else begin
         case (state)
            BANK_IDLE: begin
               if (accept) begin
                  state   <= BANK_BUSY;
                  lat_cnt <= CNT_W'(`MEM_BANK_DELAY - 1);
               end
            end
            BANK_BUSY: begin
               if (lat_cnt == '0) begin
                  state <= BANK_DONE;
               end else begin
                  lat_cnt <= lat_cnt - 1'b1;
               end
            end
            BANK_DONE: begin
               if (bus.r_ready) begin                   // r_valid is high here
                  state <= BANK_IDLE;
               end
            end
            default: state <= BANK_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         cmd_r <= bus.c_cmd;
      end
   end

   always_ff @(posedge clk) begin
      if (sweep_on) begin
         mem[sweep_idx] <= '0;
      end else if (do_access && cmd_r.op == OP_WRITE) begin
         for (int b = 0; b < `MEM_BE_W; b++) begin
            if (cmd_r.be[b]) begin
               mem[word_idx][8*b +: 8] <= cmd_r.wdata[8*b +: 8];
            end
         end
      end
   end

   // Writes answer with zero data
   always_ff @(posedge clk) begin
      if (do_access) begin
         bus.r_rdata <= (cmd_r.op == OP_READ) ? mem[word_idx] : '0;
      end
   end

endmodule

// ==== common/bank_if.sv ====
// Bank interface: command and response handshakes of one SRAM bank

`include "mem_consts.svh"

interface bank_if import mem_cmd_pkg::*; ();

   logic                c_valid;
   logic                c_ready;
   mem_cmd_t            c_cmd;

   logic                r_valid;
   logic                r_ready;
   logic [`MEM_DW-1:0]  r_rdata;

   // Router also watches response transfers to track the bank's occupancy
   modport router (
      output c_valid,
      output c_cmd,
      input  c_ready,
      input  r_valid,
      input  r_ready
   );

   modport bank (
      input  c_valid,
      input  c_cmd,
      output c_ready,
      output r_valid,
      output r_rdata,
      input  r_ready
   );

   modport merge (
      output r_ready,
      input  r_valid,
      input  r_rdata
   );

endinterface

// ==== common/mem_ctl_pkg.sv ====
// Control package: bank state machine encoding and bank selection

package mem_ctl_pkg;

   typedef enum logic [1:0] {
      BANK_IDLE = 2'd0,                   // Ready for a command
      BANK_BUSY = 2'd1,                   // Counting out the latency
      BANK_DONE = 2'd2                    // Response held until r_ready
   } bank_state_e;

   // Address bit 2 picks the bank
   typedef enum logic {
      BANK_EVEN = 1'b0,
      BANK_ODD  = 1'b1
   } bank_sel_t;

endpackage

// ==== common/mem_cmd_pkg.sv ====
// Command package: opcode and command layout carried to the banks

`include "mem_consts.svh"

package mem_cmd_pkg;

   typedef enum logic {
      OP_READ  = 1'b0,
      OP_WRITE = 1'b1
   } mem_op_e;

   typedef struct packed {
      mem_op_e               op;
      logic [`MEM_AW-1:0]    addr;        // Byte address, bits 1:0 ignored
      logic [`MEM_DW-1:0]    wdata;
      logic [`MEM_BE_W-1:0]  be;          // Byte enables for writes
   } mem_cmd_t;

endpackage

// ==== common/mem_consts.svh ====
// Memory constants for the two-bank interleaved word memory

`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// Data path
`define MEM_DW 32
`define MEM_AW 16                       // Byte address
`define MEM_BE_W (`MEM_DW/8)

// Bank geometry and timing
`define MEM_BANK_WORDS 1024             // Words per bank
`define MEM_BANK_DELAY 3                // Accept to r_valid, at least 1

// Response ordering
`define MEM_ORDER_DEPTH 4               // Power of two

`endif
